// File: frogger_top.f
+incdir+source
source/frogger_pkg.sv
source/debounce_filter.sv
source/game_fsm.sv
source/step_timer.sv
source/frog_movement.sv
source/obstacle_lanes.sv
source/collision_detect.sv
source/score_display.sv
source/frogger_top.sv
tb/tb_frogger_top.sv

// File: tb/tb_frogger_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "frogger_macros.svh"

module tb_frogger_top;

    localparam int HOLD_CYCLES  = `DEBOUNCE_LIMIT + 4;
    localparam int PRESS_CYCLES = 2 * HOLD_CYCLES + 1;

    localparam frogger_pkg::frog_pos_t START_POS = '{
        row: '0,
        col: frogger_pkg::col_t'(`FROG_START_COL)
    };

    localparam frogger_pkg::car_lanes_t START_CARS = '{
        lane0: frogger_pkg::col_t'(`CAR_START_0),
        lane1: frogger_pkg::col_t'(`CAR_START_1),
        lane2: frogger_pkg::col_t'(`CAR_START_2),
        lane3: frogger_pkg::col_t'(`CAR_START_3)
    };

    localparam frogger_pkg::switch_t SW_UP    = 4'b1000;
    localparam frogger_pkg::switch_t SW_LEFT  = 4'b0100;
    localparam frogger_pkg::switch_t SW_RIGHT = 4'b0010;
    localparam frogger_pkg::switch_t SW_DOWN  = 4'b0001;
    localparam frogger_pkg::switch_t SW_ALL   = 4'b1111;

    logic                    i_Clk = 1'b0;
    logic                    i_rst_n;
    frogger_pkg::switch_t    i_switch;
    frogger_pkg::frog_pos_t  o_frog;
    frogger_pkg::car_lanes_t o_cars;
    logic                    o_game_active;
    frogger_pkg::level_t     o_level;
    frogger_pkg::score_t     o_score;
    frogger_pkg::seg_t       o_seg_tens;
    frogger_pkg::seg_t       o_seg_ones;

    // Previous samples of the DUT outputs
    logic                    p_act;
    logic                    p2_act;
    frogger_pkg::frog_pos_t  p_frog;
    frogger_pkg::score_t     p_score;
    frogger_pkg::level_t     p_level;
    frogger_pkg::level_t     p2_level;
    frogger_pkg::car_lanes_t p_cars;
    logic                    p_hit;
    logic                    score_chg_d;
    logic                    ev_d;

    // Reference state
    logic [7:0]              m_lfsr = `LFSR_SEED;
    logic [3:0]              m_dir = 4'h0;
    logic [15:0]             rand_state = 16'd40952;
    int                      gap = 0;
    int                      m_exp = 0;
    frogger_pkg::frog_pos_t  m_frog;
    frogger_pkg::score_t     m_score;
    logic                    check_model;
    logic                    check_reset;

    logic                    w_run3;
    logic                    w_score_chg;
    logic                    w_car_chg;
    logic                    w_start_load;
    logic                    w_hit_now;
    logic [7:0]              w_lfsr_step;

    frogger_top DUT (
        .i_Clk         (i_Clk),
        .i_rst_n       (i_rst_n),
        .i_switch      (i_switch),
        .o_frog        (o_frog),
        .o_cars        (o_cars),
        .o_game_active (o_game_active),
        .o_level       (o_level),
        .o_score       (o_score),
        .o_seg_tens    (o_seg_tens),
        .o_seg_ones    (o_seg_ones)
    );

    always #50 i_Clk = ~i_Clk;

    function automatic frogger_pkg::seg_t seg_of(frogger_pkg::digit_t d);
        case (d)
            4'd0:    return 7'b1111110;
            4'd1:    return 7'b0110000;
            4'd2:    return 7'b1101101;
            4'd3:    return 7'b1111001;
            4'd4:    return 7'b0110011;
            4'd5:    return 7'b1011011;
            4'd6:    return 7'b1011111;
            4'd7:    return 7'b1110000;
            4'd8:    return 7'b1111111;
            4'd9:    return 7'b1111011;
            default: return 7'b0000000;
        endcase
    endfunction

    function automatic frogger_pkg::score_t bcd_inc(frogger_pkg::score_t s);
        frogger_pkg::score_t r;
        r = s;
        if (s.ones < 4'd9)
            r.ones = s.ones + 4'd1;
        else
        begin
            r.ones = 4'd0;
            r.tens = (s.tens < 4'd9) ? s.tens + 4'd1 : 4'd0;
        end
        return r;
    endfunction

    function automatic frogger_pkg::level_t level_inc(frogger_pkg::level_t l);
        return (l == 4'd15) ? l : l + 4'd1;
    endfunction

    function automatic int step_period(frogger_pkg::level_t l);
        int p;
        p = `STEP_BASE - `STEP_DEC * int'(l);
        return (p < `STEP_MIN) ? `STEP_MIN : p;
    endfunction

    // Taps 8, 6, 5, 4 feed the new bit 0
    function automatic logic [7:0] next_lfsr(logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic frogger_pkg::col_t lane_col(frogger_pkg::car_lanes_t c, int k);
        case (k)
            0:       return c.lane0;
            1:       return c.lane1;
            2:       return c.lane2;
            default: return c.lane3;
        endcase
    endfunction

    function automatic frogger_pkg::col_t move_col(frogger_pkg::col_t c, logic d, int n);
        return d ? c + frogger_pkg::col_t'(n) : c - frogger_pkg::col_t'(n);
    endfunction

    function automatic frogger_pkg::car_lanes_t step_cars(frogger_pkg::car_lanes_t c,
                                                          logic [3:0] d);
        frogger_pkg::car_lanes_t r;
        r.lane0 = move_col(c.lane0, d[0], 1);
        r.lane1 = move_col(c.lane1, d[1], 1);
        r.lane2 = move_col(c.lane2, d[2], 1);
        r.lane3 = move_col(c.lane3, d[3], 1);
        return r;
    endfunction

    function automatic logic frog_hit(frogger_pkg::frog_pos_t f, frogger_pkg::car_lanes_t c);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < 4; k++)
        begin
            if ((int'(f.row) == k + 1) && (f.col == lane_col(c, k)))
                hit = 1'b1;
        end
        return hit;
    endfunction

    // Every car position that may show up while the frog sits on its lane
    function automatic logic safe_to_cross(frogger_pkg::col_t col, frogger_pkg::car_lanes_t c,
                                           logic [3:0] d, frogger_pkg::level_t l);
        int  p;
        int  j_lo;
        int  j_hi;
        logic ok;
        p  = step_period(l);
        ok = 1'b1;
        for (int k = 0; k < 4; k++)
        begin
            j_lo = (PRESS_CYCLES * k + `DEBOUNCE_LIMIT - 2) / p;
            j_hi = (PRESS_CYCLES * (k + 1) + `DEBOUNCE_LIMIT + 4) / p + 1;
            for (int j = j_lo; j <= j_hi; j++)
            begin
                if (move_col(lane_col(c, k), d[k], j) == col)
                    ok = 1'b0;
            end
        end
        return ok;
    endfunction

    function automatic logic take_bit();
        logic fb;
        fb = rand_state[15] ^ rand_state[13] ^ rand_state[12] ^ rand_state[10];
        rand_state = {rand_state[14:0], fb};
        return rand_state[0];
    endfunction

    task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] act);
        $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, exp, act);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    assign w_run3       = o_game_active && p_act && p2_act;
    assign w_score_chg  = w_run3 && (o_score != p_score);
    assign w_car_chg    = w_run3 && (o_cars != p_cars);
    assign w_start_load = o_game_active && p_act && !p2_act;
    assign w_hit_now    = frog_hit(o_frog, o_cars);
    assign w_lfsr_step  = next_lfsr(m_lfsr);

    always @(posedge i_Clk)
    begin
        p_act       <= o_game_active;
        p2_act      <= p_act;
        p_frog      <= o_frog;
        p_score     <= o_score;
        p_level     <= o_level;
        p2_level    <= p_level;
        p_cars      <= o_cars;
        p_hit       <= o_game_active && w_hit_now;
        score_chg_d <= w_score_chg;
        // Directions reload on each start and level-up
        ev_d        <= (o_game_active && !p_act) || w_score_chg;
        if (ev_d)
        begin
            m_lfsr <= w_lfsr_step;
            m_dir  <= w_lfsr_step[3:0];
        end
        if (w_start_load)
        begin
            gap   <= 1;
            m_exp <= `STEP_BASE + 1;
        end
        else if (w_car_chg)
        begin
            gap   <= 1;
            m_exp <= step_period(p2_level);
        end
        else
        begin
            gap <= gap + 1;
        end
    end

    a_reset_state : assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        check_reset |-> ({o_game_active, o_frog, o_score, o_level, o_cars, o_seg_tens,
            o_seg_ones} == {1'b0, START_POS, 8'h00, 4'h0, START_CARS, seg_of(0), seg_of(0)}))
        else report_mismatch("reset outputs",
            {1'b0, START_POS, 8'h00, 4'h0, START_CARS, seg_of(0), seg_of(0)},
            $sampled({o_game_active, o_frog, o_score, o_level, o_cars, o_seg_tens, o_seg_ones}));

    a_segments : assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        {o_seg_tens, o_seg_ones} == {seg_of(p_score.tens), seg_of(p_score.ones)})
        else report_mismatch("o_seg_tens/o_seg_ones",
            {seg_of($sampled(p_score.tens)), seg_of($sampled(p_score.ones))},
            $sampled({o_seg_tens, o_seg_ones}));

    a_idle_frog : assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        (!o_game_active && !p_act) |-> (o_frog == p_frog))
        else report_mismatch("o_frog", $sampled(p_frog), $sampled(o_frog));

    a_idle_cars : assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        (!o_game_active && !p_act && !p2_act) |-> (o_cars == p_cars))
        else report_mismatch("o_cars", $sampled(p_cars), $sampled(o_cars));

    a_start_load : assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        w_start_load |-> ({o_frog, o_score, o_level, o_cars} ==
            {START_POS, 8'h00, 4'h0, START_CARS}))
        else report_mismatch("start outputs", {START_POS, 8'h00, 4'h0, START_CARS},
            $sampled({o_frog, o_score, o_level, o_cars}));

    a_frog_model : assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        check_model |-> ({o_frog, o_score} == {m_frog, m_score}))
        else report_mismatch("o_frog/o_score", {m_frog, m_score}, $sampled({o_frog, o_score}));

    a_score_step : assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        w_score_chg |-> ({o_score, o_frog} == {bcd_inc(p_score), START_POS}))
        else report_mismatch("o_score/o_frog", {bcd_inc($sampled(p_score)), START_POS},
            $sampled({o_score, o_frog}));

    a_level : assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        w_run3 |-> (o_level == (score_chg_d ? level_inc(p_level) : p_level)))
        else report_mismatch("o_level",
            $sampled(score_chg_d) ? level_inc($sampled(p_level)) : $sampled(p_level),
            $sampled(o_level));

    a_car_step : assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        w_car_chg |-> (o_cars == step_cars(p_cars, m_dir)))
        else report_mismatch("o_cars", step_cars($sampled(p_cars), $sampled(m_dir)),
            $sampled(o_cars));

    a_step_period : assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        w_car_chg |-> (gap == m_exp))
        else report_mismatch("car step period", $sampled(m_exp), $sampled(gap));

    a_hit_ends : assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        (o_game_active && w_hit_now && !p_hit) |-> ##[1:2] !o_game_active)
        else report_failure("game stayed active after the frog was hit by a car");

    a_hit_reset : assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        (p_act && !o_game_active) |-> ({o_frog, o_score} == {START_POS, p_score}))
        else report_mismatch("o_frog/o_score", {START_POS, $sampled(p_score)},
            $sampled({o_frog, o_score}));

    task automatic press(frogger_pkg::switch_t sw);
        i_switch = sw;
        repeat (HOLD_CYCLES) @(posedge i_Clk);
        #5;
        i_switch = '0;
        repeat (HOLD_CYCLES) @(posedge i_Clk);
        #5;
    endtask

    // Press one switch and follow it in the model
    task automatic move(frogger_pkg::switch_t sw);
        logic active;
        active      = o_game_active;
        check_model = 1'b0;
        press(sw);
        if (active)
        begin
            if (sw.up && (m_frog.row == frogger_pkg::row_t'(`GOAL_ROW - 1)))
            begin
                m_frog  = START_POS;
                m_score = bcd_inc(m_score);
            end
            else if (sw.up)
                m_frog.row = m_frog.row + 1'b1;
            else if (sw.down && (m_frog.row != '0))
                m_frog.row = m_frog.row - 1'b1;
            else if (sw.left && (m_frog.col != '0))
                m_frog.col = m_frog.col - 1'b1;
            else if (sw.right && (m_frog.col != frogger_pkg::col_t'(`NUM_COLS - 1)))
                m_frog.col = m_frog.col + 1'b1;
        end
        check_model = 1'b1;
        @(posedge i_Clk);
        #5;
    endtask

    task automatic wait_active(logic want, int limit, string what);
        int n;
        n = 0;
        while ((o_game_active != want) && (n < limit))
        begin
            @(posedge i_Clk);
            #5;
            n++;
        end
        if (o_game_active != want)
            report_failure(what);
    endtask

    task automatic start_round();
        check_model = 1'b0;
        press(SW_ALL);
        wait_active(1'b1, 8, "timeout waiting for the game to start");
        m_frog      = START_POS;
        m_score     = '0;
        check_model = 1'b1;
    endtask

    task automatic cross_to_goal();
        int n;
        n = 0;
        while (!safe_to_cross(m_frog.col, o_cars, m_dir, o_level) && (n < 3000))
        begin
            @(posedge i_Clk);
            #5;
            n++;
        end
        if (!safe_to_cross(m_frog.col, o_cars, m_dir, o_level))
            report_failure("timeout waiting for a safe moment to cross the lanes");
        repeat (`GOAL_ROW) move(SW_UP);
    endtask

    initial
    begin
        i_rst_n     = 1'b0;
        i_switch    = '0;
        check_model = 1'b0;
        check_reset = 1'b0;
        m_frog      = START_POS;
        m_score     = '0;
        repeat (3) @(posedge i_Clk);
        #5;
        i_rst_n     = 1'b1;
        check_reset = 1'b1;
        @(posedge i_Clk);
        #5;
        check_reset = 1'b0;
        check_model = 1'b1;

        // Nothing moves while idle
        move(SW_UP);
        move(SW_RIGHT);

        start_round();
        repeat (12)
        begin
            case ({take_bit(), take_bit()})
                2'b00:   move(SW_LEFT);
                2'b10:   move(SW_DOWN);
                default: move(SW_RIGHT);
            endcase
        end
        // Grid edges
        repeat (`NUM_COLS) move(SW_LEFT);
        move(SW_DOWN);
        repeat (`NUM_COLS + 1) move(SW_RIGHT);

        // Ten goals take the score through a carry
        repeat (10) cross_to_goal();

        // Park on lane 0 until its car arrives
        check_model = 1'b0;
        press(SW_UP);
        wait_active(1'b0, 3000, "timeout waiting for the car in lane 0 to hit the frog");
        m_frog      = START_POS;
        check_model = 1'b1;
        move(SW_LEFT);
        move(SW_UP);

        start_round();
        repeat (3) move(SW_RIGHT);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/frogger_top.sv
`timescale 1ns/1ps
`default_nettype none

module frogger_top (
    input  wire                         i_Clk,
    input  wire                         i_rst_n,
    input  wire frogger_pkg::switch_t   i_switch,
    output frogger_pkg::frog_pos_t      o_frog,
    output frogger_pkg::car_lanes_t     o_cars,
    output logic                        o_game_active,
    output frogger_pkg::level_t         o_level,
    output frogger_pkg::score_t         o_score,
    output frogger_pkg::seg_t           o_seg_tens,
    output frogger_pkg::seg_t           o_seg_ones
);

    wire frogger_pkg::switch_t w_switch;
    logic                      w_start;
    logic                      w_level_up;
    logic                      w_car_step;
    logic                      w_collided;

    // One filter per push switch
    for (genvar k = 0; k < 4; k++)
    begin : g_debounce
        debounce_filter u_debounce (
            .i_Clk    (i_Clk),
            .i_rst_n  (i_rst_n),
            .i_switch (i_switch[k]),
            .o_switch (w_switch[k])
        );
    end

    game_fsm u_game_fsm (
        .i_Clk         (i_Clk),
        .i_rst_n       (i_rst_n),
        .i_switch      (w_switch),
        .i_collided    (w_collided),
        .o_start       (w_start),
        .o_game_active (o_game_active)
    );

    step_timer u_step_timer (
        .i_Clk         (i_Clk),
        .i_rst_n       (i_rst_n),
        .i_start       (w_start),
        .i_game_active (o_game_active),
        .i_level_up    (w_level_up),
        .o_level       (o_level),
        .o_car_step    (w_car_step)
    );

    frog_movement u_frog_movement (
        .i_Clk         (i_Clk),
        .i_rst_n       (i_rst_n),
        .i_switch      (w_switch),
        .i_start       (w_start),
        .i_game_active (o_game_active),
        .i_collided    (w_collided),
        .o_frog        (o_frog),
        .o_score       (o_score),
        .o_level_up    (w_level_up)
    );

    obstacle_lanes u_obstacle_lanes (
        .i_Clk      (i_Clk),
        .i_rst_n    (i_rst_n),
        .i_start    (w_start),
        .i_level_up (w_level_up),
        .i_car_step (w_car_step),
        .o_cars     (o_cars)
    );

    collision_detect u_collision_detect (
        .i_Clk         (i_Clk),
        .i_rst_n       (i_rst_n),
        .i_frog        (o_frog),
        .i_cars        (o_cars),
        .i_game_active (o_game_active),
        .o_collided    (w_collided)
    );

    score_display u_score_display (
        .i_Clk      (i_Clk),
        .i_rst_n    (i_rst_n),
        .i_score    (o_score),
        .o_seg_tens (o_seg_tens),
        .o_seg_ones (o_seg_ones)
    );

endmodule

`default_nettype wire

// File: source/score_display.sv
`timescale 1ns/1ps
`default_nettype none

module score_display (
    input  wire                     i_Clk,
    input  wire                     i_rst_n,
    input  wire frogger_pkg::score_t i_score,
    output frogger_pkg::seg_t       o_seg_tens,
    output frogger_pkg::seg_t       o_seg_ones
);

    // Segments a..g, active high
    function automatic frogger_pkg::seg_t digit_to_seg(frogger_pkg::digit_t digit);
        case (digit)
            4'd0:    return 7'h7E;
            4'd1:    return 7'h30;
            4'd2:    return 7'h6D;
            4'd3:    return 7'h79;
            4'd4:    return 7'h33;
            4'd5:    return 7'h5B;
            4'd6:    return 7'h5F;
            4'd7:    return 7'h70;
            4'd8:    return 7'h7F;
            4'd9:    return 7'h7B;
            default: return 7'h00;
        endcase
    endfunction

    always_ff @(posedge i_Clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            // Show 00 out of reset
            o_seg_tens <= digit_to_seg('0);
            o_seg_ones <= digit_to_seg('0);
        end
        else
        begin
            o_seg_tens <= digit_to_seg(i_score.tens);
            o_seg_ones <= digit_to_seg(i_score.ones);
        end
    end

endmodule

`default_nettype wire

// File: source/collision_detect.sv
`timescale 1ns/1ps
`default_nettype none

module collision_detect (
    input  wire                         i_Clk,
    input  wire                         i_rst_n,
    input  wire frogger_pkg::frog_pos_t i_frog,
    input  wire frogger_pkg::car_lanes_t i_cars,
    input  wire                         i_game_active,
    output logic                        o_collided
);

    frogger_pkg::col_t w_lane_col [4];
    logic              w_hit;
    logic              r_overlap;
    logic              r_overlap_d;

    // Lane k sits on row k+1
    always_comb
    begin
        w_lane_col[0] = i_cars.lane0;
        w_lane_col[1] = i_cars.lane1;
        w_lane_col[2] = i_cars.lane2;
        w_lane_col[3] = i_cars.lane3;
        w_hit = 1'b0;
        for (int k = 0; k < 4; k++)
        begin
            if ((i_frog.row == frogger_pkg::row_t'(k + 1)) && (i_frog.col == w_lane_col[k]))
                w_hit = 1'b1;
        end
    end

    always_ff @(posedge i_Clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_overlap   <= 1'b0;
            r_overlap_d <= 1'b0;
        end
        else
        begin
            r_overlap   <= i_game_active && w_hit;
            r_overlap_d <= r_overlap;
        end
    end

    // First cycle of an overlap only
    assign o_collided = r_overlap && !r_overlap_d;

endmodule

`default_nettype wire

// File: source/obstacle_lanes.sv
`timescale 1ns/1ps
`default_nettype none

`include "frogger_macros.svh"

module obstacle_lanes (
    input  wire                     i_Clk,
    input  wire                     i_rst_n,
    input  wire                     i_start,
    input  wire                     i_level_up,
    input  wire                     i_car_step,
    output frogger_pkg::car_lanes_t o_cars
);

    localparam int NUM_LANES = 4;

    localparam frogger_pkg::col_t START_COL [NUM_LANES] = '{
        frogger_pkg::col_t'(`CAR_START_0),
        frogger_pkg::col_t'(`CAR_START_1),
        frogger_pkg::col_t'(`CAR_START_2),
        frogger_pkg::col_t'(`CAR_START_3)
    };

    logic [7:0]             r_lfsr;
    logic [7:0]             w_lfsr_next;
    logic [NUM_LANES-1:0]   r_dir;
    frogger_pkg::col_t      r_cars [NUM_LANES];

    // Taps 8, 6, 5, 4
    assign w_lfsr_next = {r_lfsr[6:0], r_lfsr[7] ^ r_lfsr[5] ^ r_lfsr[4] ^ r_lfsr[3]};

    always_ff @(posedge i_Clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_lfsr <= `LFSR_SEED;
            r_dir  <= '0;
            for (int k = 0; k < NUM_LANES; k++)
                r_cars[k] <= START_COL[k];
        end
        else
        begin
            // New directions each round and each level
            if (i_start || i_level_up)
            begin
                r_lfsr <= w_lfsr_next;
                r_dir  <= w_lfsr_next[NUM_LANES-1:0];
            end

            if (i_start)
            begin
                for (int k = 0; k < NUM_LANES; k++)
                    r_cars[k] <= START_COL[k];
            end
            else if (i_car_step)
            begin
                // 4-bit columns wrap on their own
                for (int k = 0; k < NUM_LANES; k++)
                    r_cars[k] <= r_dir[k] ? r_cars[k] + 1'b1 : r_cars[k] - 1'b1;
            end
        end
    end

    always_comb
    begin
        o_cars.lane0 = r_cars[0];
        o_cars.lane1 = r_cars[1];
        o_cars.lane2 = r_cars[2];
        o_cars.lane3 = r_cars[3];
    end

endmodule

`default_nettype wire

// File: source/frog_movement.sv
`timescale 1ns/1ps
`default_nettype none

`include "frogger_macros.svh"

module frog_movement (
    input  wire                     i_Clk,
    input  wire                     i_rst_n,
    input  wire frogger_pkg::switch_t i_switch,
    input  wire                     i_start,
    input  wire                     i_game_active,
    input  wire                     i_collided,
    output frogger_pkg::frog_pos_t  o_frog,
    output frogger_pkg::score_t     o_score,
    output logic                    o_level_up
);

    localparam frogger_pkg::frog_pos_t START_POS = '{
        row: '0,
        col: frogger_pkg::col_t'(`FROG_START_COL)
    };

    frogger_pkg::switch_t   r_switch_prev;
    frogger_pkg::switch_t   w_rise;
    frogger_pkg::frog_pos_t w_frog_next;
    frogger_pkg::score_t    w_score_next;
    logic                   w_goal;

    assign w_rise = i_switch & ~r_switch_prev;

    // One move per press, up first if several arrive together
    always_comb
    begin
        w_frog_next = o_frog;
        w_goal      = 1'b0;
        if (w_rise.up)
        begin
            if (o_frog.row == frogger_pkg::row_t'(`GOAL_ROW - 1))
                w_goal = 1'b1;
            else
                w_frog_next.row = o_frog.row + 1'b1;
        end
        else if (w_rise.down)
        begin
            if (o_frog.row != '0)
                w_frog_next.row = o_frog.row - 1'b1;
        end
        else if (w_rise.left)
        begin
            if (o_frog.col != '0)
                w_frog_next.col = o_frog.col - 1'b1;
        end
        else if (w_rise.right)
        begin
            if (o_frog.col != frogger_pkg::col_t'(`NUM_COLS - 1))
                w_frog_next.col = o_frog.col + 1'b1;
        end
    end

    // BCD increment, 99 rolls over to 00
    always_comb
    begin
        w_score_next = o_score;
        if (o_score.ones == 4'd9)
        begin
            w_score_next.ones = '0;
            w_score_next.tens = (o_score.tens == 4'd9) ? '0 : o_score.tens + 1'b1;
        end
        else
        begin
            w_score_next.ones = o_score.ones + 1'b1;
        end
    end

    always_ff @(posedge i_Clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_switch_prev <= '0;
            o_frog        <= START_POS;
            o_score       <= '0;
            o_level_up    <= 1'b0;
        end
        else
        begin
            r_switch_prev <= i_switch;
            o_level_up    <= 1'b0;
            if (i_start)
            begin
                o_frog  <= START_POS;
                o_score <= '0;
            end
            else if (i_game_active)
            begin
                if (i_collided)
                begin
                    o_frog <= START_POS;
                end
                else if (w_goal)
                begin
                    o_frog     <= START_POS;
                    o_score    <= w_score_next;
                    o_level_up <= 1'b1;
                end
                else
                begin
                    o_frog <= w_frog_next;
                end
            end
        end
    end

    a_row_below_goal : assert property (
        @(posedge i_Clk) disable iff (!i_rst_n)
        o_frog.row < frogger_pkg::row_t'(`GOAL_ROW)
    ) else $error("frog row reached the goal row without a reset to start");

    a_score_decimal : assert property (
        @(posedge i_Clk) disable iff (!i_rst_n)
        (o_score.tens <= 4'd9) && (o_score.ones <= 4'd9)
    ) else $error("score digit above 9");

endmodule

`default_nettype wire

// File: source/step_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "frogger_macros.svh"

module step_timer (
    input  wire                  i_Clk,
    input  wire                  i_rst_n,
    input  wire                  i_start,
    input  wire                  i_game_active,
    input  wire                  i_level_up,
    output frogger_pkg::level_t  o_level,
    output logic                 o_car_step
);

    localparam int CNT_W = $clog2(`STEP_BASE);

    logic [CNT_W-1:0] r_count;

    // Period minus one, shorter at higher levels, floored at the minimum
    function automatic logic [CNT_W-1:0] reload_value(frogger_pkg::level_t lvl);
        int period;
        period = `STEP_BASE - int'(lvl) * `STEP_DEC;
        if (period < `STEP_MIN)
            period = `STEP_MIN;
        return CNT_W'(period - 1);
    endfunction

    always_ff @(posedge i_Clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_level    <= '0;
            r_count    <= CNT_W'(`STEP_BASE - 1);
            o_car_step <= 1'b0;
        end
        else
        begin
            o_car_step <= 1'b0;
            if (i_start)
            begin
                o_level <= '0;
                r_count <= CNT_W'(`STEP_BASE - 1);
            end
            else
            begin
                // Saturate at the top level
                if (i_level_up && (o_level != '1))
                    o_level <= o_level + 1'b1;

                if (i_game_active)
                begin
                    if (r_count == '0)
                    begin
                        r_count    <= reload_value(o_level);
                        o_car_step <= 1'b1;
                    end
                    else
                    begin
                        r_count <= r_count - 1'b1;
                    end
                end
            end
        end
    end

    a_step_single : assert property (
        @(posedge i_Clk) disable iff (!i_rst_n)
        o_car_step |=> !o_car_step
    ) else $error("car-step strobe held for more than one cycle");

endmodule

`default_nettype wire

// File: source/game_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module game_fsm (
    input  wire                   i_Clk,
    input  wire                   i_rst_n,
    input  wire frogger_pkg::switch_t i_switch,
    input  wire                   i_collided,
    output logic                  o_start,
    output logic                  o_game_active
);

    frogger_pkg::game_state_e r_state;
    logic                     w_all_held;

    assign w_all_held = &i_switch;

    always_ff @(posedge i_Clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_state <= frogger_pkg::ST_IDLE;
            o_start <= 1'b0;
        end
        else
        begin
            o_start <= 1'b0;
            case (r_state)
                frogger_pkg::ST_IDLE:
                begin
                    // All four held together starts a round
                    if (w_all_held)
                    begin
                        r_state <= frogger_pkg::ST_RUNNING;
                        o_start <= 1'b1;
                    end
                end
                frogger_pkg::ST_RUNNING:
                begin
                    if (i_collided)
                        r_state <= frogger_pkg::ST_IDLE;
                end
                default:
                begin
                    r_state <= frogger_pkg::ST_IDLE;
                end
            endcase
        end
    end

    assign o_game_active = (r_state == frogger_pkg::ST_RUNNING);

    a_start_from_idle : assert property (
        @(posedge i_Clk) disable iff (!i_rst_n)
        o_start |-> ($past(r_state) == frogger_pkg::ST_IDLE) && o_game_active
    ) else $error("start strobe without an idle to running transition");

    a_start_single : assert property (
        @(posedge i_Clk) disable iff (!i_rst_n)
        o_start |=> !o_start
    ) else $error("start strobe held for more than one cycle");

endmodule

`default_nettype wire

// File: source/debounce_filter.sv
`timescale 1ns/1ps
`default_nettype none

`include "frogger_macros.svh"

module debounce_filter (
    input  wire  i_Clk,
    input  wire  i_rst_n,
    input  wire  i_switch,
    output logic o_switch
);

    localparam int CNT_W = $clog2(`DEBOUNCE_LIMIT + 1);

    logic [CNT_W-1:0] r_count;

    // Count only while the raw input disagrees with the filtered level
    always_ff @(posedge i_Clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_count  <= '0;
            o_switch <= 1'b0;
        end
        else if (i_switch != o_switch)
        begin
            if (r_count == CNT_W'(`DEBOUNCE_LIMIT - 1))
            begin
                o_switch <= i_switch;
                r_count  <= '0;
            end
            else
            begin
                r_count <= r_count + 1'b1;
            end
        end
        else
        begin
            r_count <= '0;
        end
    end

    a_change_needs_limit : assert property (
        @(posedge i_Clk) disable iff (!i_rst_n)
        (o_switch != $past(o_switch)) |-> ($past(r_count) == CNT_W'(`DEBOUNCE_LIMIT - 1))
    ) else $error("debounce output changed before the limit was reached");

endmodule

`default_nettype wire

// File: source/frogger_pkg.sv
`default_nettype none

package frogger_pkg;

    // Grid coordinates
    typedef logic [3:0] col_t;
    typedef logic [2:0] row_t;

    typedef struct packed {
        row_t row;
        col_t col;
    } frog_pos_t;

    // Two-digit decimal score
    typedef logic [3:0] digit_t;

    typedef struct packed {
        digit_t tens;
        digit_t ones;
    } score_t;

    // Bit 6 is segment a, bit 0 is segment g
    typedef logic [6:0] seg_t;

    typedef logic [3:0] level_t;

    typedef struct packed {
        logic up;
        logic left;
        logic right;
        logic down;
    } switch_t;

    // Lane k runs along row k+1
    typedef struct packed {
        col_t lane0;
        col_t lane1;
        col_t lane2;
        col_t lane3;
    } car_lanes_t;

    typedef enum logic {
        ST_IDLE    = 1'b0,
        ST_RUNNING = 1'b1
    } game_state_e;

endpackage

`default_nettype wire

// File: source/frogger_macros.svh
`ifndef FROGGER_MACROS_SVH
`define FROGGER_MACROS_SVH

// Playfield
`define NUM_COLS        16
`define GOAL_ROW        5
`define FROG_START_COL  7

// Switch filtering, in clock cycles
`define DEBOUNCE_LIMIT  8

// Car-step period, in clock cycles
`define STEP_BASE       64
`define STEP_DEC        4
`define STEP_MIN        16

// Lane direction generator
`define LFSR_SEED       8'hA5

// Car start columns
`define CAR_START_0     0
`define CAR_START_1     4
`define CAR_START_2     8
`define CAR_START_3     12

`endif
